/* design/tc_defines.svh */
`ifndef TC_DEFINES_SVH
`define TC_DEFINES_SVH

// data path width of one lane
`define TC_XLEN         32

// lanes served by the octet
`define TC_LANES        8

// warps sharing the octet, and the width of a warp id
`define TC_NUM_WARPS    2
`define TC_WID_W        1

// destination register index width
`define TC_RD_W         5

// per-warp metadata entries, enough for two pairs in flight per warp
`define TC_META_DEPTH   4

// result tiles that can wait for writeback
`define TC_OUTBUF_DEPTH 2

// dot unit pipeline depth in cycles, must be at least 2
`define TC_DPU_LATENCY  3

`endif

/* design/tc_pkg.sv */
`include "tc_defines.svh"

package tc_pkg;

    // a single lane word
    typedef logic [`TC_XLEN-1:0] word_t;

    // one word per lane, lane 0 in the low bits
    typedef logic [`TC_LANES*`TC_XLEN-1:0] lanes_t;

    // four words of an operand half
    typedef logic [4*`TC_XLEN-1:0] half_t;

    // 4x4 tile stored row-major, element [r][c] is word 4r+c
    typedef logic [16*`TC_XLEN-1:0] tile_t;

    typedef logic [`TC_WID_W-1:0] wid_t;

    typedef logic [`TC_RD_W-1:0] rd_t;

    // bit 0 picks the A lane group, bit 1 picks the B half
    typedef logic [1:0] step_t;

    // which pair of D columns is on the commit bus
    typedef enum logic {
        HALF_LO = 1'b0,
        HALF_HI = 1'b1
    } commit_half_e;

endpackage

/* design/tc_operand_stager.sv */
`timescale 1ns/1ps
`include "tc_defines.svh"

module tc_operand_stager import tc_pkg::*; (
    input  logic   clk,
    input  logic   reset,

    input  logic   in_valid,
    input  wid_t   in_wid,
    input  step_t  in_step,
    input  logic   in_last,
    input  lanes_t in_a,
    input  lanes_t in_b,
    input  lanes_t in_c,
    output logic   stage_ready,

    output logic   issue_valid,
    output wid_t   issue_wid,
    output lanes_t issue_a,
    output lanes_t issue_b,
    output tile_t  issue_c,
    input  logic   issue_ready
);
    localparam int W = `TC_XLEN;

    // operands of the first instruction of a pair, kept per warp
    half_t  buf_a [`TC_NUM_WARPS];
    half_t  buf_b [`TC_NUM_WARPS];
    lanes_t buf_c [`TC_NUM_WARPS];

    // set while a warp has a first half waiting for its partner
    logic [`TC_NUM_WARPS-1:0] held;

    half_t  cur_a;
    half_t  cur_b;
    half_t  use_a;
    half_t  use_b;
    lanes_t use_c;

    logic store_first;
    logic fire_second;

    // a first instruction only writes the buffers, so it never waits
    assign stage_ready = in_last ? issue_ready : 1'b1;
    assign store_first = in_valid && !in_last;
    assign fire_second = issue_valid && issue_ready;

    assign issue_valid = in_valid && in_last;
    assign issue_wid   = in_wid;

    always_comb begin
        // A comes from the two 2x2 lane groups of the selected column pair
        if (in_step[0]) begin
            cur_a = {in_a[7*W +: W], in_a[6*W +: W], in_a[3*W +: W], in_a[2*W +: W]};
        end else begin
            cur_a = {in_a[5*W +: W], in_a[4*W +: W], in_a[1*W +: W], in_a[0*W +: W]};
        end

        // B is shared by both thread groups, one half of the lanes per step
        cur_b = in_step[1] ? in_b[4*W +: 4*W] : in_b[0 +: 4*W];
    end

    // a warp without a stored first half contributes zeros
    assign use_a = held[in_wid] ? buf_a[in_wid] : '0;
    assign use_b = held[in_wid] ? buf_b[in_wid] : '0;
    assign use_c = held[in_wid] ? buf_c[in_wid] : '0;

    always_comb begin
        int e;

        // A tile is 4x2, word 2r+k, k=0 from the buffer and k=1 current
        for (int r = 0; r < 4; r++) begin
            issue_a[(2*r)*W +: W]   = use_a[r*W +: W];
            issue_a[(2*r+1)*W +: W] = cur_a[r*W +: W];
        end

        // B tile is 2x4 with the buffered row as row 0
        issue_b = {cur_b, use_b};

        // C rows interleave buffered and current lanes, rows 2 and 3
        // come from the upper thread group
        for (int r = 0; r < 4; r++) begin
            e = (r < 2) ? r : r + 2;
            issue_c[(4*r+0)*W +: W] = use_c[e*W +: W];
            issue_c[(4*r+1)*W +: W] = in_c[e*W +: W];
            issue_c[(4*r+2)*W +: W] = use_c[(e+2)*W +: W];
            issue_c[(4*r+3)*W +: W] = in_c[(e+2)*W +: W];
        end
    end

    always_ff @(posedge clk) begin
        if (store_first) begin
            buf_a[in_wid] <= cur_a;
            buf_b[in_wid] <= cur_b;
            buf_c[in_wid] <= in_c;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            held <= '0;
        end else begin
            if (store_first) begin
                held[in_wid] <= 1'b1;
            end else if (fire_second) begin
                held[in_wid] <= 1'b0;
            end
        end
    end

endmodule

/* design/tc_dot_unit.sv */
`timescale 1ns/1ps
`include "tc_defines.svh"

module tc_dot_unit import tc_pkg::*; (
    input  logic   clk,
    input  logic   reset,

    input  logic   issue_valid,
    input  wid_t   issue_wid,
    input  lanes_t issue_a,
    input  lanes_t issue_b,
    input  tile_t  issue_c,
    output logic   issue_ready,

    output logic   dpu_valid,
    output wid_t   dpu_wid,
    output tile_t  dpu_d,
    input  logic   dpu_ready
);
    localparam int W   = `TC_XLEN;
    localparam int LAT = `TC_DPU_LATENCY;

    // stage valid bits, bit LAT-1 is the output stage
    logic [LAT-1:0] vld;
    wid_t           wid_q [LAT];

    // first stage keeps the two partial products and the addend
    tile_t prod0_q;
    tile_t prod1_q;
    tile_t c_q;

    // sums travel through the remaining stages
    tile_t d_q [LAT-1];

    tile_t prod0;
    tile_t prod1;
    tile_t sum;
    logic  advance;

    // everything moves together, so one stalled output freezes all stages
    assign advance     = !(vld[LAT-1] && !dpu_ready);
    assign issue_ready = advance;

    always_comb begin
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                prod0[(4*r+c)*W +: W] = issue_a[(2*r)*W +: W] * issue_b[c*W +: W];
                prod1[(4*r+c)*W +: W] = issue_a[(2*r+1)*W +: W] * issue_b[(4+c)*W +: W];
            end
        end
    end

    // wrapping sum of both products and C, one word per element
    always_comb begin
        for (int i = 0; i < 16; i++) begin
            sum[i*W +: W] = prod0_q[i*W +: W] + prod1_q[i*W +: W] + c_q[i*W +: W];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            vld <= '0;
        end else if (advance) begin
            vld <= {vld[LAT-2:0], issue_valid};
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            prod0_q  <= prod0;
            prod1_q  <= prod1;
            c_q      <= issue_c;
            wid_q[0] <= issue_wid;
            d_q[0]   <= sum;
            for (int i = 1; i < LAT; i++) begin
                wid_q[i] <= wid_q[i-1];
            end
            for (int i = 1; i < LAT-1; i++) begin
                d_q[i] <= d_q[i-1];
            end
        end
    end

    assign dpu_valid = vld[LAT-1];
    assign dpu_wid   = wid_q[LAT-1];
    assign dpu_d     = d_q[LAT-2];

endmodule

/* design/tc_writeback.sv */
`timescale 1ns/1ps
`include "tc_defines.svh"

module tc_writeback import tc_pkg::*; (
    input  logic         clk,
    input  logic         reset,

    input  logic         dpu_valid,
    input  wid_t         dpu_wid,
    input  tile_t        dpu_d,
    output logic         dpu_ready,

    input  logic         meta_push,
    input  wid_t         meta_wid,
    input  rd_t          meta_rd,
    output logic         meta_full,

    output logic         commit_valid,
    output wid_t         commit_wid,
    output rd_t          commit_rd,
    output commit_half_e commit_half,
    output lanes_t       commit_data,
    input  logic         commit_ready
);
    localparam int W     = `TC_XLEN;
    localparam int NW    = `TC_NUM_WARPS;
    localparam int OB_D  = `TC_OUTBUF_DEPTH;
    localparam int MQ_D  = `TC_META_DEPTH;
    localparam int OB_AW = (OB_D > 1) ? $clog2(OB_D) : 1;
    localparam int MQ_AW = (MQ_D > 1) ? $clog2(MQ_D) : 1;

    // result buffer between the dot unit and the commit bus
    tile_t            ob_tile [OB_D];
    wid_t             ob_wid  [OB_D];
    logic [OB_AW-1:0] ob_wr_ptr;
    logic [OB_AW-1:0] ob_rd_ptr;
    logic [OB_AW:0]   ob_count;
    logic             ob_push;
    logic             ob_pop;

    // destination registers in issue order, one queue per warp
    rd_t              mq_mem    [NW][MQ_D];
    logic [MQ_AW-1:0] mq_wr_ptr [NW];
    logic [MQ_AW-1:0] mq_rd_ptr [NW];
    logic [MQ_AW:0]   mq_count  [NW];
    logic [NW-1:0]    mq_push;
    logic [NW-1:0]    mq_pop;

    commit_half_e half_q;
    logic         commit_fire;
    tile_t        d_head;

    assign dpu_ready    = (ob_count != (OB_AW+1)'(OB_D));
    assign ob_push      = dpu_valid && dpu_ready;
    assign commit_valid = (ob_count != '0);
    assign commit_fire  = commit_valid && commit_ready;

    // the tile stays until both of its beats have gone out
    assign ob_pop = commit_fire && (half_q == HALF_HI);

    assign d_head      = ob_tile[ob_rd_ptr];
    assign commit_wid  = ob_wid[ob_rd_ptr];
    assign commit_half = half_q;
    assign commit_rd   = mq_mem[commit_wid][mq_rd_ptr[commit_wid]];
    assign meta_full   = (mq_count[meta_wid] == (MQ_AW+1)'(MQ_D));

    always_ff @(posedge clk) begin
        if (ob_push) begin
            ob_tile[ob_wr_ptr] <= dpu_d;
            ob_wid[ob_wr_ptr]  <= dpu_wid;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ob_wr_ptr <= '0;
            ob_rd_ptr <= '0;
            ob_count  <= '0;
        end else begin
            if (ob_push) begin
                ob_wr_ptr <= (ob_wr_ptr == OB_AW'(OB_D-1)) ? '0 : ob_wr_ptr + 1'b1;
            end
            if (ob_pop) begin
                ob_rd_ptr <= (ob_rd_ptr == OB_AW'(OB_D-1)) ? '0 : ob_rd_ptr + 1'b1;
            end
            if (ob_push && !ob_pop) begin
                ob_count <= ob_count + 1'b1;
            end else if (!ob_push && ob_pop) begin
                ob_count <= ob_count - 1'b1;
            end
        end
    end

    // each instruction pushes once and each beat pops once
    always_comb begin
        for (int w = 0; w < NW; w++) begin
            mq_push[w] = meta_push && (meta_wid == wid_t'(w));
            mq_pop[w]  = commit_fire && (commit_wid == wid_t'(w));
        end
    end

    always_ff @(posedge clk) begin
        if (meta_push) begin
            mq_mem[meta_wid][mq_wr_ptr[meta_wid]] <= meta_rd;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int w = 0; w < NW; w++) begin
                mq_wr_ptr[w] <= '0;
                mq_rd_ptr[w] <= '0;
                mq_count[w]  <= '0;
            end
        end else begin
            for (int w = 0; w < NW; w++) begin
                if (mq_push[w]) begin
                    mq_wr_ptr[w] <= (mq_wr_ptr[w] == MQ_AW'(MQ_D-1)) ? '0 : mq_wr_ptr[w] + 1'b1;
                end
                if (mq_pop[w]) begin
                    mq_rd_ptr[w] <= (mq_rd_ptr[w] == MQ_AW'(MQ_D-1)) ? '0 : mq_rd_ptr[w] + 1'b1;
                end
                if (mq_push[w] && !mq_pop[w]) begin
                    mq_count[w] <= mq_count[w] + 1'b1;
                end else if (!mq_push[w] && mq_pop[w]) begin
                    mq_count[w] <= mq_count[w] - 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            half_q <= HALF_LO;
        end else if (commit_fire) begin
            half_q <= (half_q == HALF_LO) ? HALF_HI : HALF_LO;
        end
    end

    // lanes 0..3 carry rows 0,1 and lanes 4..7 rows 2,3 of the
    // even columns on the low beat and of the odd columns on the high beat
    always_comb begin
        int r;
        int c;

        for (int l = 0; l < `TC_LANES; l++) begin
            r = ((l >= 4) ? 2 : 0) + (l % 2);
            c = (((l % 4) >= 2) ? 2 : 0) + ((half_q == HALF_HI) ? 1 : 0);
            commit_data[l*W +: W] = d_head[(4*r+c)*W +: W];
        end
    end

endmodule

/* design/tc_octet_core.sv */
`timescale 1ns/1ps

module tc_octet_core import tc_pkg::*; (
    input  logic         clk,
    input  logic         reset,

    input  logic         in_valid,
    input  wid_t         in_wid,
    input  rd_t          in_rd,
    input  step_t        in_step,
    input  logic         in_last,
    input  lanes_t       in_a,
    input  lanes_t       in_b,
    input  lanes_t       in_c,
    output logic         in_ready,

    output logic         commit_valid,
    output wid_t         commit_wid,
    output rd_t          commit_rd,
    output commit_half_e commit_half,
    output lanes_t       commit_data,
    input  logic         commit_ready
);
    logic   stage_valid;
    logic   stage_ready;
    logic   meta_full;
    logic   meta_push;

    logic   issue_valid;
    wid_t   issue_wid;
    lanes_t issue_a;
    lanes_t issue_b;
    tile_t  issue_c;
    logic   issue_ready;

    logic   dpu_valid;
    wid_t   dpu_wid;
    tile_t  dpu_d;
    logic   dpu_ready;

    // an instruction enters only if its rd has somewhere to go, which keeps
    // the stager and the metadata queues in step
    assign stage_valid = in_valid && !meta_full;
    assign in_ready    = stage_ready && !meta_full;
    assign meta_push   = in_valid && in_ready;

    tc_operand_stager tc_operand_stager_inst (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (stage_valid),
        .in_wid      (in_wid),
        .in_step     (in_step),
        .in_last     (in_last),
        .in_a        (in_a),
        .in_b        (in_b),
        .in_c        (in_c),
        .stage_ready (stage_ready),
        .issue_valid (issue_valid),
        .issue_wid   (issue_wid),
        .issue_a     (issue_a),
        .issue_b     (issue_b),
        .issue_c     (issue_c),
        .issue_ready (issue_ready)
    );

    tc_dot_unit tc_dot_unit_inst (
        .clk         (clk),
        .reset       (reset),
        .issue_valid (issue_valid),
        .issue_wid   (issue_wid),
        .issue_a     (issue_a),
        .issue_b     (issue_b),
        .issue_c     (issue_c),
        .issue_ready (issue_ready),
        .dpu_valid   (dpu_valid),
        .dpu_wid     (dpu_wid),
        .dpu_d       (dpu_d),
        .dpu_ready   (dpu_ready)
    );

    tc_writeback tc_writeback_inst (
        .clk          (clk),
        .reset        (reset),
        .dpu_valid    (dpu_valid),
        .dpu_wid      (dpu_wid),
        .dpu_d        (dpu_d),
        .dpu_ready    (dpu_ready),
        .meta_push    (meta_push),
        .meta_wid     (in_wid),
        .meta_rd      (in_rd),
        .meta_full    (meta_full),
        .commit_valid (commit_valid),
        .commit_wid   (commit_wid),
        .commit_rd    (commit_rd),
        .commit_half  (commit_half),
        .commit_data  (commit_data),
        .commit_ready (commit_ready)
    );

endmodule

/* test/tc_octet_sva.sv */
`timescale 1ns/1ps
`include "tc_defines.svh"

module tc_octet_sva import tc_pkg::*; (
    input logic         clk,
    input logic         reset,
    input logic         in_valid,
    input logic         in_ready,
    input wid_t         in_wid,
    input rd_t          in_rd,
    input step_t        in_step,
    input logic         in_last,
    input lanes_t       in_a,
    input lanes_t       in_b,
    input lanes_t       in_c,
    input logic         commit_valid,
    input logic         commit_ready,
    input wid_t         commit_wid,
    input rd_t          commit_rd,
    input commit_half_e commit_half,
    input lanes_t       commit_data
);

    // an offered beat stays put until the consumer takes it
    commit_hold_a: assert property (@(posedge clk) disable iff (reset)
        commit_valid && !commit_ready |=> commit_valid && $stable(commit_wid)
            && $stable(commit_rd) && $stable(commit_half) && $stable(commit_data))
        else $error("commit beat changed while it was stalled");

    commit_reset_a: assert property (@(posedge clk)
        reset |=> !commit_valid)
        else $error("commit_valid high after a reset cycle");

    // every accepted beat flips the half, nothing else does
    half_toggle_a: assert property (@(posedge clk) disable iff (reset)
        commit_valid && commit_ready |=> commit_half != $past(commit_half))
        else $error("commit_half did not advance after an accepted beat");

    half_keep_a: assert property (@(posedge clk) disable iff (reset)
        !(commit_valid && commit_ready) |=> $stable(commit_half))
        else $error("commit_half moved without an accepted beat");

    // the source side must hold a refused instruction
    in_hold_a: assert property (@(posedge clk) disable iff (reset)
        in_valid && !in_ready |=> in_valid && $stable(in_wid) && $stable(in_rd)
            && $stable(in_step) && $stable(in_last) && $stable(in_a)
            && $stable(in_b) && $stable(in_c))
        else $error("input instruction changed while it was refused");

endmodule

bind tc_octet_core tc_octet_sva tc_octet_sva_inst (
    .clk          (clk),
    .reset        (reset),
    .in_valid     (in_valid),
    .in_ready     (in_ready),
    .in_wid       (in_wid),
    .in_rd        (in_rd),
    .in_step      (in_step),
    .in_last      (in_last),
    .in_a         (in_a),
    .in_b         (in_b),
    .in_c         (in_c),
    .commit_valid (commit_valid),
    .commit_ready (commit_ready),
    .commit_wid   (commit_wid),
    .commit_rd    (commit_rd),
    .commit_half  (commit_half),
    .commit_data  (commit_data)
);

/* test/tc_octet_tb.sv */
`timescale 1ns/1ps
`include "tc_defines.svh"

module tc_octet_tb import tc_pkg::*; ();

    localparam int W            = `TC_XLEN;
    localparam int LAT          = `TC_DPU_LATENCY;
    localparam int STEP_LIMIT   = 2000;
    localparam int DRAIN_LIMIT  = 20000;
    localparam int RANDOM_PAIRS = 200;

    typedef struct packed {
        wid_t         wid;
        rd_t          rd;
        commit_half_e half;
        lanes_t       data;
    } beat_t;

    logic         clk;
    logic         reset;
    logic         in_valid;
    wid_t         in_wid;
    rd_t          in_rd;
    step_t        in_step;
    logic         in_last;
    lanes_t       in_a;
    lanes_t       in_b;
    lanes_t       in_c;
    logic         in_ready;
    logic         commit_valid;
    wid_t         commit_wid;
    rd_t          commit_rd;
    commit_half_e commit_half;
    lanes_t       commit_data;
    logic         commit_ready = 1'b1;

    // model copy of the first instruction of each warp's open pair
    half_t  ref_a   [`TC_NUM_WARPS];
    half_t  ref_b   [`TC_NUM_WARPS];
    lanes_t ref_c   [`TC_NUM_WARPS];
    rd_t    ref_rd  [`TC_NUM_WARPS];
    logic   pending [`TC_NUM_WARPS];

    // beats the DUT still owes, in commit order
    beat_t exp_q [$];

    logic ready_pattern [1024];
    logic bp_on = 1'b0;
    int   ready_idx = 0;
    int   seed;
    int   errors = 0;
    int   beats_checked = 0;
    int   tests_run = 0;
    int   tests_failed = 0;
    logic timed_out = 1'b0;

    tc_octet_core tc_octet_core_inst (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (in_valid),
        .in_wid       (in_wid),
        .in_rd        (in_rd),
        .in_step      (in_step),
        .in_last      (in_last),
        .in_a         (in_a),
        .in_b         (in_b),
        .in_c         (in_c),
        .in_ready     (in_ready),
        .commit_valid (commit_valid),
        .commit_wid   (commit_wid),
        .commit_rd    (commit_rd),
        .commit_half  (commit_half),
        .commit_data  (commit_data),
        .commit_ready (commit_ready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // A lanes 0,1,4,5 or 2,3,6,7 become half words 0..3
    function automatic half_t pick_a_half(lanes_t a, step_t step);
        half_t h;
        int    lane;
        for (int i = 0; i < 4; i++) begin
            lane = i + 2 * (i / 2) + (step[0] ? 2 : 0);
            h[i*W +: W] = a[lane*W +: W];
        end
        return h;
    endfunction

    function automatic half_t pick_b_half(lanes_t b, step_t step);
        half_t h;
        for (int i = 0; i < 4; i++) begin
            h[i*W +: W] = b[(i + (step[1] ? 4 : 0))*W +: W];
        end
        return h;
    endfunction

    // D = A*B + C for the warp's open pair, queued as its LO and HI beats
    function automatic void expect_pair(wid_t wid, rd_t rd_second, half_t cur_a,
                                        half_t cur_b, lanes_t cur_c);
        word_t d [4][4];
        word_t c_elem;
        beat_t beat;
        int    e;
        int    r;
        int    c;
        for (int i = 0; i < 4; i++) begin
            e = i + 2 * (i / 2);
            for (int j = 0; j < 4; j++) begin
                // even columns from the first instruction, odd from the second
                c_elem = (j % 2 == 1) ? cur_c[(e + 2 * (j / 2))*W +: W]
                                      : ref_c[wid][(e + 2 * (j / 2))*W +: W];
                d[i][j] = ref_a[wid][i*W +: W] * ref_b[wid][j*W +: W]
                        + cur_a[i*W +: W] * cur_b[j*W +: W] + c_elem;
            end
        end
        for (int h = 0; h < 2; h++) begin
            beat.wid  = wid;
            beat.rd   = (h == 1) ? rd_second : ref_rd[wid];
            beat.half = (h == 1) ? HALF_HI : HALF_LO;
            for (int l = 0; l < `TC_LANES; l++) begin
                r = 2 * (l / 4) + l % 2;
                c = 2 * ((l / 2) % 2) + h;
                beat.data[l*W +: W] = d[r][c];
            end
            exp_q.push_back(beat);
        end
    endfunction

    task automatic finish_run();
        $display("summary: %0d tests, %0d failed, %0d beats checked, %0d errors",
                 tests_run, tests_failed, beats_checked, errors);
        if (errors == 0 && !timed_out) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        timed_out = 1'b1;
        $display("timeout: %s made no progress within the cycle limit at %0t", what, $time);
        finish_run();
    endtask

    task automatic end_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, errors - errors_before);
        end
    endtask

    // called on a falling edge, returns on the falling edge after the transfer
    task automatic send_instr(input wid_t wid, input step_t step, input logic last);
        lanes_t      a;
        lanes_t      b;
        lanes_t      c;
        logic [31:0] rnd;
        int          waited;
        for (int l = 0; l < `TC_LANES; l++) begin
            a[l*W +: W] = $random(seed);
            b[l*W +: W] = $random(seed);
            c[l*W +: W] = $random(seed);
        end
        rnd      = $random(seed);
        in_valid = 1'b1;
        in_wid   = wid;
        in_rd    = rnd[`TC_RD_W-1:0];
        in_step  = step;
        in_last  = last;
        in_a     = a;
        in_b     = b;
        in_c     = c;
        waited   = 0;
        @(posedge clk);
        while (!in_ready) begin
            if (waited >= STEP_LIMIT) report_timeout("input handshake");
            waited++;
            @(posedge clk);
        end
        if (!last) begin
            ref_a[wid]   = pick_a_half(a, step);
            ref_b[wid]   = pick_b_half(b, step);
            ref_c[wid]   = c;
            ref_rd[wid]  = rnd[`TC_RD_W-1:0];
            pending[wid] = 1'b1;
        end else begin
            expect_pair(wid, rnd[`TC_RD_W-1:0], pick_a_half(a, step), pick_b_half(b, step), c);
            pending[wid] = 1'b0;
        end
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    // next instruction of a warp, first or second as its pair state says
    task automatic issue_next(input wid_t wid);
        logic [31:0] rnd;
        rnd = $random(seed);
        send_instr(wid, rnd[1:0], pending[wid]);
    endtask

    task automatic wait_drain(input string what);
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            if (waited >= DRAIN_LIMIT) report_timeout(what);
            waited++;
            @(negedge clk);
        end
    endtask

    always @(negedge clk) begin
        commit_ready = bp_on ? ready_pattern[ready_idx] : 1'b1;
        ready_idx    = (ready_idx + 1) % 1024;
    end

    // every accepted beat must be the oldest one the model expects
    always @(posedge clk) begin
        beat_t want;
        if (!reset && commit_valid && commit_ready) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("unexpected commit beat from warp %0d with nothing outstanding",
                         commit_wid);
            end else begin
                want = exp_q.pop_front();
                beats_checked++;
                if (commit_wid !== want.wid || commit_rd !== want.rd
                        || commit_half !== want.half) begin
                    errors++;
                    $display("[ERROR] %0t: beat %0d wid/rd/half %0d/%0d/%0d, expected %0d/%0d/%0d",
                             $time, beats_checked, commit_wid, commit_rd, commit_half,
                             want.wid, want.rd, want.half);
                end
                if (commit_data !== want.data) begin
                    errors++;
                    $display("[ERROR] %0t: beat %0d data %h, expected %h",
                             $time, beats_checked, commit_data, want.data);
                end
            end
        end
    end

    initial begin
        int          start_errors;
        int          waited;
        int          started;
        int          finished;
        logic [31:0] rnd;
        wid_t        w;

        seed     = 35;
        reset    = 1'b1;
        in_valid = 1'b0;
        in_wid   = '0;
        in_rd    = '0;
        in_step  = '0;
        in_last  = 1'b0;
        in_a     = '0;
        in_b     = '0;
        in_c     = '0;
        for (int i = 0; i < `TC_NUM_WARPS; i++) begin
            pending[i] = 1'b0;
        end
        for (int i = 0; i < 1024; i++) begin
            rnd = $random(seed);
            ready_pattern[i] = rnd[0];
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        start_errors = errors;
        if (commit_valid !== 1'b0 || in_ready !== 1'b1 || commit_half !== HALF_LO) begin
            errors++;
            $display("[ERROR] %0t: after reset commit_valid %b in_ready %b commit_half %0d",
                     $time, commit_valid, in_ready, commit_half);
        end
        end_test("reset state", start_errors);

        start_errors = errors;
        issue_next(0);
        issue_next(0);
        waited = 0;
        while (!commit_valid) begin
            if (waited >= STEP_LIMIT) report_timeout("first commit beat");
            waited++;
            @(negedge clk);
        end
        // the beat is taken on the rising edge after valid is seen
        if (waited + 1 < LAT + 1) begin
            errors++;
            $display("[ERROR] %0t: first beat after %0d cycles, expected at least %0d",
                     $time, waited + 1, LAT + 1);
        end
        wait_drain("single pair");
        end_test("single pair", start_errors);

        start_errors = errors;
        for (int s1 = 0; s1 < 4; s1++) begin
            for (int s2 = 0; s2 < 4; s2++) begin
                send_instr(wid_t'(s2 % 2), step_t'(s1), 1'b0);
                send_instr(wid_t'(s2 % 2), step_t'(s2), 1'b1);
            end
        end
        wait_drain("step sweep");
        end_test("step sweep", start_errors);

        start_errors = errors;
        for (int p = 0; p < 4; p++) begin
            issue_next(0);
            issue_next(1);
            issue_next(0);
            issue_next(1);
        end
        wait_drain("interleaved warps");
        end_test("interleaved warps", start_errors);

        start_errors = errors;
        @(posedge clk);
        bp_on = 1'b1;
        @(negedge clk);
        started  = 0;
        finished = 0;
        while (finished < RANDOM_PAIRS) begin
            rnd = $random(seed);
            w   = rnd[`TC_WID_W-1:0];
            // once all pairs are started only the other warp can have one open
            if (!pending[w] && started >= RANDOM_PAIRS) begin
                w = ~w;
            end
            if (pending[w]) begin
                finished++;
            end else begin
                started++;
            end
            issue_next(w);
        end
        wait_drain("random back-pressure");
        @(posedge clk);
        bp_on = 1'b0;
        @(negedge clk);
        for (int i = 0; i < 10; i++) begin
            if (commit_valid) begin
                errors++;
                $display("extra commit beat from warp %0d after all pairs committed", commit_wid);
            end
            @(negedge clk);
        end
        end_test("random back-pressure", start_errors);

        finish_run();
    end

endmodule

/* vlog.f */
+incdir+design
design/tc_pkg.sv
design/tc_operand_stager.sv
design/tc_dot_unit.sv
design/tc_writeback.sv
design/tc_octet_core.sv
test/tc_octet_sva.sv
test/tc_octet_tb.sv

/* run.sh */
#!/bin/bash
# build the octet testbench with Verilator, run it, and decide on the log contents

cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

# a failed build or a simulation that stops on its own also counts as failure
verilator --binary --timing --assert -Wno-fatal -f vlog.f \
    --top-module tc_octet_tb -o tc_octet_sim > build.log 2>&1 \
    && ./obj_dir/tc_octet_sim > sim.log 2>&1 \
    || { cat build.log; echo "TESTS FAILED" >> sim.log; }

cat sim.log

if grep -q "TESTS FAILED" sim.log; then
    exit 1
fi
exit 0
